// File: flist.f
design/stoch_pkg.sv
design/serial_deframer.sv
design/stoch_source.sv
design/integrator_chain.sv
design/result_serializer.sv
design/stoch_integrator_top.sv
dv/tb_stoch_integrator_asserts.sv
dv/tb_stoch_integrator.sv

// File: Makefile
TOP := tb_stoch_integrator

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir

// File: dv/tb_stoch_integrator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stoch_integrator import stoch_pkg::*; ();

    localparam int NUM_ROWS = 5;
    localparam int SETTLE   = 4;  // Words that may still show the previous row

    typedef enum logic [1:0] {EXP_ZERO, EXP_RISING, EXP_FALLING, EXP_BOUND} exp_class_t;

    typedef struct packed {
        value_t     a;
        value_t     b;
        int         frames;  // Frames sent for this row
        exp_class_t cls;     // Expected trend of the received words
    } row_t;

    logic   clk;
    logic   rst_n;
    logic   in_a;
    logic   in_b;
    logic   frame_end;
    logic   out_v1;
    logic   out_v2;
    logic   out_v3;
    logic   sn_c;
    row_t   table_rows [NUM_ROWS];
    integer seed = 43;
    int     errors;
    int     failed_rows;

    stoch_integrator_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_a      (in_a),
        .in_b      (in_b),
        .frame_end (frame_end),
        .out_v1    (out_v1),
        .out_v2    (out_v2),
        .out_v3    (out_v3),
        .sn_c      (sn_c)
    );

    always #20 clk = ~clk;  // 40 ns period

    task automatic check_eq(input string name, input value_t got, input value_t exp);
        if (got != exp) begin
            $display("error %s got 0x%03h expected 0x%03h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_le(input string name, input value_t lo, input value_t hi);
        if (lo > hi) begin
            $display("error %s 0x%03h above 0x%03h", name, lo, hi);
            errors++;
        end
    endtask

    // Falling edges until frame_end marks slot 9
    task automatic wait_frame_end(input int limit);
        int n;
        n = 0;
        while (!frame_end && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!frame_end) begin
            $display("timeout: frame_end did not pulse within %0d cycles", limit);
            $display("ERRORS FOUND");
            $finish;
        end
    endtask

    // Sends one frame and receives one, entered at the falling edge of slot 9
    task automatic run_frame(input value_t a, input value_t b, output integ_values_t w,
                             output logic [2:0] dummy, output logic sn_c_seen);
        sn_c_seen = 1'b0;
        for (int k = 0; k < FRAME_LEN; k++) begin
            @(negedge clk);
            if (k < VALUE_W) begin
                in_a    = a[k];  // LSB first
                in_b    = b[k];
                w.v1[k] = out_v1;
                w.v2[k] = out_v2;
                w.v3[k] = out_v3;
            end else begin
                in_a  = 1'b0;  // Dummy slot
                in_b  = 1'b0;
                dummy = {out_v1, out_v2, out_v3};
            end
            sn_c_seen = sn_c_seen | sn_c;
        end
        if (!frame_end) begin
            $display("frame_end lost alignment with the sent frames");
            errors++;
        end
    endtask

    initial begin
        integ_values_t w;
        integ_values_t prev;
        logic [2:0]    dummy;
        logic          sn_c_seen;
        int            row_errors;

        clk         = 1'b0;
        rst_n       = 1'b1;  // Reset is active high
        in_a        = 1'b0;
        in_b        = 1'b0;
        errors      = 0;
        failed_rows = 0;
        table_rows[0] = '{a: '0, b: '0, frames: 6, cls: EXP_ZERO};
        table_rows[1] = '{a: '0, b: VALUE_MAX, frames: 6, cls: EXP_ZERO};
        table_rows[2] = '{a: VALUE_MAX, b: '0, frames: 30, cls: EXP_RISING};
        table_rows[3] = '{a: '0, b: VALUE_MAX, frames: 45, cls: EXP_FALLING};
        table_rows[4].a      = value_t'($random(seed));
        table_rows[4].b      = value_t'($random(seed));
        table_rows[4].frames = 12;
        table_rows[4].cls    = EXP_BOUND;

        repeat (4) @(negedge clk);
        rst_n = 1'b0;
        if ({frame_end, out_v1, out_v2, out_v3, sn_c} != 5'b0) begin
            $display("error outputs after reset got 0x%02h expected 0x00",
                     {frame_end, out_v1, out_v2, out_v3, sn_c});
            errors++;
        end
        wait_frame_end(FRAME_LEN);

        for (int r = 0; r < NUM_ROWS; r++) begin
            row_errors = errors;
            prev       = '0;
            for (int f = 0; f < table_rows[r].frames; f++) begin
                run_frame(table_rows[r].a, table_rows[r].b, w, dummy, sn_c_seen);
                check_eq("dummy bits of out_v1..3", value_t'(dummy), '0);
                case (table_rows[r].cls)
                    EXP_ZERO: begin  // Nothing can increment with a at 0
                        check_eq("out_v1", w.v1, '0);
                        check_eq("out_v2", w.v2, '0);
                        check_eq("out_v3", w.v3, '0);
                        check_eq("sn_c", value_t'(sn_c_seen), '0);
                    end
                    EXP_RISING: begin
                        if (f >= SETTLE) begin
                            check_le("previous out_v1", prev.v1, w.v1);
                        end
                    end
                    EXP_FALLING: begin
                        if (f >= SETTLE) begin
                            check_le("out_v1", w.v1, prev.v1);
                        end
                    end
                    default: begin
                    end
                endcase
                prev = w;
            end

            // Final word of the row
            if (table_rows[r].cls == EXP_RISING) begin
                if (w.v1 == '0) begin
                    $display("error out_v1 got 0x000 expected above 0x000");
                    errors++;
                end
                check_le("out_v2 over out_v1", w.v2, w.v1);
                check_le("out_v3 over out_v2", w.v3, w.v2);
            end else if (table_rows[r].cls == EXP_FALLING) begin
                check_eq("out_v1", w.v1, '0);
                check_eq("out_v2", w.v2, '0);
                check_eq("out_v3", w.v3, '0);
            end
            if (errors != row_errors) begin
                failed_rows++;
            end
            $display("row %0d a=0x%03h b=0x%03h frames %0d: %s", r, table_rows[r].a,
                     table_rows[r].b, table_rows[r].frames,
                     (errors == row_errors) ? "pass" : "fail");
        end

        if (u_dut.u_chain.u_asserts.fail_count != 0) begin
            $display("integrator chain assertions failed %0d times",
                     u_dut.u_chain.u_asserts.fail_count);
            errors += u_dut.u_chain.u_asserts.fail_count;
        end

        $display("rows %0d, failed rows %0d, error count %0d", NUM_ROWS, failed_rows, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_stoch_integrator_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module integrator_chain_asserts import stoch_pkg::*; (
    input wire           clk,
    input wire           rst_n,
    input integ_values_t values,
    input wire           sn_c
);

    value_t cnt [3];
    int     fail_count = 0;  // Failed assertions so far

    assign cnt[0] = values.v1;
    assign cnt[1] = values.v2;
    assign cnt[2] = values.v3;

    for (genvar i = 0; i < 3; i++) begin : g_cnt
        // Hold, or one step either way
        a_step: assert property (@(posedge clk) disable iff (rst_n)
            (cnt[i] == $past(cnt[i])) || (cnt[i] - $past(cnt[i]) == 9'd1)
                || ($past(cnt[i]) - cnt[i] == 9'd1))
            else begin
                fail_count++;
                $error("counter %0d moved by more than one", i);
            end

        // Saturation at both ends
        a_no_wrap: assert property (@(posedge clk) disable iff (rst_n)
            !(($past(cnt[i]) == VALUE_MAX) && (cnt[i] == '0))
                && !(($past(cnt[i]) == '0) && (cnt[i] == VALUE_MAX)))
            else begin
                fail_count++;
                $error("counter %0d wrapped", i);
            end
    end

    a_sn_c_zero: assert property (@(posedge clk) disable iff (rst_n)
        (values.v3 == '0) |-> !sn_c)  // Zero value never beats a random word
        else begin
            fail_count++;
            $error("sn_c high while v3 is zero");
        end

endmodule

bind integrator_chain integrator_chain_asserts u_asserts (
    .clk    (clk),
    .rst_n  (rst_n),
    .values (values),
    .sn_c   (sn_c)
);

`default_nettype wire

// File: design/stoch_integrator_top.sv
`timescale 1ns/1ps
`default_nettype none

module stoch_integrator_top import stoch_pkg::*; #(
    parameter logic [LFSR_W-1:0] LFSR_SEED       = DEFAULT_SEED,
    parameter int                SNAPSHOT_FRAMES = 2
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  in_a,       // Serial probability a
    input  wire  in_b,       // Serial probability b
    output logic frame_end,  // Input frames align to this
    output logic out_v1,
    output logic out_v2,
    output logic out_v3,
    output logic sn_c        // Raw stream of counter 3
);

    value_t        prob_a;
    value_t        prob_b;
    sn_in_t        sn_in;
    rand_words_t   rand_words;
    integ_values_t values;

    serial_deframer u_deframer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_a      (in_a),
        .in_b      (in_b),
        .prob_a    (prob_a),
        .prob_b    (prob_b),
        .frame_end (frame_end)
    );

    // Producer
    stoch_source #(
        .LFSR_SEED (LFSR_SEED)
    ) u_source (
        .clk        (clk),
        .rst_n      (rst_n),
        .prob_a     (prob_a),
        .prob_b     (prob_b),
        .sn_in      (sn_in),
        .rand_words (rand_words)
    );

    // Accumulated state
    integrator_chain u_chain (
        .clk        (clk),
        .rst_n      (rst_n),
        .sn_in      (sn_in),
        .rand_words (rand_words),
        .values     (values),
        .sn_c       (sn_c)
    );

    // Consumer
    result_serializer #(
        .SNAPSHOT_FRAMES (SNAPSHOT_FRAMES)
    ) u_serializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .frame_end (frame_end),
        .values    (values),
        .out_v1    (out_v1),
        .out_v2    (out_v2),
        .out_v3    (out_v3)
    );

endmodule

`default_nettype wire

// File: design/result_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module result_serializer import stoch_pkg::*; #(
    parameter int SNAPSHOT_FRAMES = 2  // Frames between snapshots
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           frame_end,
    input  integ_values_t values,
    output logic          out_v1,
    output logic          out_v2,
    output logic          out_v3
);

    localparam int WORDS = 3;
    localparam int CNT_W = (SNAPSHOT_FRAMES > 1) ? $clog2(SNAPSHOT_FRAMES) : 1;

    localparam logic [CNT_W-1:0] LAST_FRAME = CNT_W'(SNAPSHOT_FRAMES - 1);

    logic [CNT_W-1:0] frame_cnt;
    logic             capture;    // Snapshot on this frame_end
    integ_values_t    snapshot;
    value_t           live [WORDS];
    value_t           held [WORDS];
    logic             ser_bit [WORDS];

    assign capture = frame_end && (frame_cnt == LAST_FRAME);

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            frame_cnt <= '0;
            snapshot  <= '0;
        end else if (frame_end) begin
            if (capture) begin
                frame_cnt <= '0;
                snapshot  <= values;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    assign live[0] = values.v1;
    assign live[1] = values.v2;
    assign live[2] = values.v3;
    assign held[0] = snapshot.v1;
    assign held[1] = snapshot.v2;
    assign held[2] = snapshot.v3;

    // Loaded at frame end, LSB out in slot 0
    // Zeros shift in, so slot 9 always sends 0
    for (genvar i = 0; i < WORDS; i++) begin : g_shift
        value_t shreg_q;

        always_ff @(posedge clk or posedge rst_n) begin
            if (rst_n) begin
                shreg_q <= '0;
            end else if (frame_end) begin
                shreg_q <= capture ? live[i] : held[i];  // New snapshot goes out at once
            end else begin
                shreg_q <= shreg_q >> 1;
            end
        end

        assign ser_bit[i] = shreg_q[0];
    end

    assign out_v1 = ser_bit[0];
    assign out_v2 = ser_bit[1];
    assign out_v3 = ser_bit[2];

endmodule

`default_nettype wire

// File: design/integrator_chain.sv
`timescale 1ns/1ps
`default_nettype none

module integrator_chain import stoch_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  sn_in_t        sn_in,
    input  rand_words_t   rand_words,
    output integ_values_t values,
    output logic          sn_c        // Bitstream of counter 3
);

    localparam int STAGES = 3;

    value_t cnt    [STAGES];  // Counter values
    value_t r_word [STAGES];  // Comparator random words
    logic   inc    [STAGES];  // Increment stream per stage
    logic   sn_bit [STAGES];  // Output stream per stage
    logic   dec;

    assign dec = sn_in.sn_b;  // Same decrement for all stages

    assign r_word[0] = rand_words.r1;
    assign r_word[1] = rand_words.r2;
    assign r_word[2] = rand_words.r3;

    // Each stage integrates the stream of the one before
    assign inc[0] = sn_in.sn_a;
    assign inc[1] = sn_bit[0];
    assign inc[2] = sn_bit[1];

    for (genvar i = 0; i < STAGES; i++) begin : g_stage
        value_t cnt_q;

        // Saturating up/down counter
        always_ff @(posedge clk or posedge rst_n) begin
            if (rst_n) begin
                cnt_q <= '0;
            end else if (inc[i] && !dec) begin
                if (cnt_q != VALUE_MAX) begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end else if (dec && !inc[i]) begin
                if (cnt_q != '0) begin  // Floor at zero
                    cnt_q <= cnt_q - 1'b1;
                end
            end
            // Both or neither set, hold
        end

        assign cnt[i]    = cnt_q;
        assign sn_bit[i] = (cnt_q > r_word[i]);  // Never 1 at zero
    end

    assign values.v1 = cnt[0];  // ~ t
    assign values.v2 = cnt[1];  // ~ t^2/2
    assign values.v3 = cnt[2];  // ~ t^3/6
    assign sn_c      = sn_bit[2];

endmodule

`default_nettype wire

// File: design/stoch_source.sv
`timescale 1ns/1ps
`default_nettype none

module stoch_source import stoch_pkg::*; #(
    parameter logic [LFSR_W-1:0] LFSR_SEED = DEFAULT_SEED
) (
    input  wire         clk,
    input  wire         rst_n,
    input  value_t      prob_a,
    input  value_t      prob_b,
    output sn_in_t      sn_in,       // Registered input bitstreams
    output rand_words_t rand_words   // Sliced from current LFSR state
);

    logic [LFSR_W-1:0] lfsr;
    logic              feedback;

    assign feedback   = lfsr[LFSR_TAP_HI] ^ lfsr[LFSR_TAP_LO];
    assign rand_words = rand_slice(lfsr);

    // Fibonacci LFSR, shifts toward the top bit
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[LFSR_W-2:0], feedback};
        end
    end

    // Stochastic number generators
    // A bit is 1 when the probability beats the random word,
    // so a zero probability never yields a 1
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            sn_in <= '0;
        end else begin
            sn_in.sn_a <= (prob_a > rand_words.ra);
            sn_in.sn_b <= (prob_b > rand_words.rb);
        end
    end

endmodule

`default_nettype wire

// File: design/serial_deframer.sv
`timescale 1ns/1ps
`default_nettype none

module serial_deframer import stoch_pkg::*; (
    input  wire    clk,
    input  wire    rst_n,
    input  wire    in_a,       // Serial frame, LSB first
    input  wire    in_b,
    output value_t prob_a,     // Stable for a whole frame
    output value_t prob_b,
    output logic   frame_end   // High during the dummy slot
);

    localparam int SLOT_W = $clog2(FRAME_LEN);

    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(FRAME_LEN - 1);
    localparam logic [SLOT_W-1:0] DATA_END  = SLOT_W'(VALUE_W);  // First non-data slot

    logic [SLOT_W-1:0] slot;   // Frame position, 0 after reset
    value_t            shift_a;
    value_t            shift_b;

    assign frame_end = (slot == LAST_SLOT);

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            slot <= '0;
        end else if (frame_end) begin
            slot <= '0;  // Wrap after dummy bit
        end else begin
            slot <= slot + 1'b1;
        end
    end

    // Bit i arrives in slot i and ends up at position i after 9 shifts
    always_ff @(posedge clk) begin
        if (slot < DATA_END) begin
            shift_a <= {in_a, shift_a[VALUE_W-1:1]};
            shift_b <= {in_b, shift_b[VALUE_W-1:1]};
        end
    end

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            prob_a <= '0;
            prob_b <= '0;
        end else if (frame_end) begin  // Dummy bit ignored
            prob_a <= shift_a;
            prob_b <= shift_b;
        end
    end

endmodule

`default_nettype wire

// File: design/stoch_pkg.sv
`default_nettype none

package stoch_pkg;

    localparam int VALUE_W   = 9;            // Probability and counter width
    localparam int FRAME_LEN = VALUE_W + 1;  // Data bits plus one dummy bit
    localparam int LFSR_W    = 31;

    localparam logic [VALUE_W-1:0] VALUE_MAX    = 9'd511;  // Saturation ceiling
    localparam int                 LFSR_TAP_HI  = 30;
    localparam int                 LFSR_TAP_LO  = 27;
    localparam logic [LFSR_W-1:0]  DEFAULT_SEED = 31'd134995;

    typedef logic [VALUE_W-1:0] value_t;

    // Random words for the five comparators
    typedef struct packed {
        value_t ra;  // Input a
        value_t rb;  // Input b
        value_t r1;  // Counter 1
        value_t r2;  // Counter 2
        value_t r3;  // Counter 3
    } rand_words_t;

    typedef struct packed {
        logic sn_a;  // Increment stream of counter 1
        logic sn_b;  // Shared decrement stream
    } sn_in_t;

    typedef struct packed {
        value_t v1;
        value_t v2;
        value_t v3;
    } integ_values_t;

    // Fixed LFSR bit positions of each random word
    // Words overlap partly but never share the same bit order
    function automatic rand_words_t rand_slice(input logic [LFSR_W-1:0] s);
        rand_words_t w;
        w.ra = s[8:0];
        w.rb = {s[5:0], s[18:16]};
        w.r1 = s[30:22];
        w.r2 = {s[15:13], s[6:1]};
        w.r3 = {s[24:19], s[14:12]};
        return w;
    endfunction

endpackage

`default_nettype wire
